// ==== hdl/fpAddSettings.svh ====
`ifndef FP_ADD_SETTINGS_SVH
`define FP_ADD_SETTINGS_SVH

// binary16 field widths
`define EXPONENT 5 // Biased exponent
`define MANTISSA 10 // Stored fraction, hidden one not counted
`define SIGN 1
`define DWIDTH (`SIGN+`EXPONENT+`MANTISSA) // Full word, 16

// Leading-zero count, must hold 0 to DWIDTH
`define SHIFT_WIDTH 5

`endif

// ==== hdl/fpAddPkg.sv ====
`include "fpAddSettings.svh"

package fpAddPkg;

	// IEEE binary16 word, sign on top
	typedef struct packed {
		logic sign;
		logic [`EXPONENT-1:0] exp; // Biased by 15
		logic [`MANTISSA-1:0] frac;
	} fpHalf;

	// Significand work vector
	// Bit 16 carry, bit 15 hidden one, then fraction
	// Low bits hold guard, round and sticky for rounding
	typedef logic [`DWIDTH:0] preSum;

	// Operand class after flushing subnormals
	typedef enum logic [1:0] {
		clsZero,
		clsNormal,
		clsInf,
		clsNan
	} opClass;

endpackage

// ==== hdl/fpAddAlign.sv ====
`timescale 1ns/1ns
`include "fpAddSettings.svh"

module fpAddAlign (
	input fpAddPkg::fpHalf a,
	input fpAddPkg::fpHalf b,
	input logic op, // 1 computes a minus b
	output logic bigSign,
	output logic [`EXPONENT-1:0] bigExp,
	output fpAddPkg::preSum bigSig,
	output fpAddPkg::preSum smallSig,
	output logic effSub,
	output logic special,
	output fpAddPkg::fpHalf specialWord,
	output logic invalidOp
);
	import fpAddPkg::*;

	localparam logic [`EXPONENT-1:0] expMax = '1;
	localparam logic [`MANTISSA-1:0] zeroFrac = '0;
	localparam fpHalf quietNan = 16'h7E00;

	opClass aCls, bCls;
	logic bSign; // Sign of b with op applied
	logic [`MANTISSA-1:0] aFrac, bFrac; // Flushed fractions
	logic [`MANTISSA-1:0] bigFrac, smallFrac;
	logic [`EXPONENT-1:0] smallExp, expDiff;
	logic swap; // b is larger in magnitude
	preSum smallFull, smallShifted, lostMask;
	logic lost; // Bits shifted past the sticky field

	function automatic opClass classify(input fpHalf x);
		opClass cls;
		if (x.exp == '0)
			cls = clsZero; // Subnormals count as zero
		else if (x.exp != expMax)
			cls = clsNormal;
		else if (x.frac == '0)
			cls = clsInf;
		else
			cls = clsNan;
		return cls;
	endfunction

	assign aCls = classify(a);
	assign bCls = classify(b);
	assign bSign = b.sign ^ op;
	assign effSub = a.sign ^ bSign; // Signs differ after op

	assign aFrac = (aCls == clsZero) ? zeroFrac : a.frac;
	assign bFrac = (bCls == clsZero) ? zeroFrac : b.frac;

	// Order by exponent, then fraction
	assign swap = {b.exp, bFrac} > {a.exp, aFrac};
	assign bigSign = swap ? bSign : a.sign;
	assign bigExp = swap ? b.exp : a.exp;
	assign bigFrac = swap ? bFrac : aFrac;
	assign smallExp = swap ? a.exp : b.exp;
	assign smallFrac = swap ? aFrac : bFrac;
	assign expDiff = bigExp - smallExp; // Never negative

	// Carry clear, hidden one only for nonzero operands
	assign bigSig = {1'b0, |bigExp, bigFrac, {(`DWIDTH-`MANTISSA-1){1'b0}}};
	assign smallFull = {1'b0, |smallExp, smallFrac, {(`DWIDTH-`MANTISSA-1){1'b0}}};

	// Mask wraps to all ones once the shift passes the vector
	assign lostMask = (preSum'(1) << expDiff) - 1'b1;
	assign smallShifted = smallFull >> expDiff;
	assign lost = |(smallFull & lostMask);
	assign smallSig = {smallShifted[`DWIDTH:1], smallShifted[0] | lost}; // Jam into bit 0

	always_comb begin
		special = 1'b1;
		invalidOp = 1'b0;
		specialWord = quietNan;
		if (aCls == clsNan || bCls == clsNan)
			specialWord = quietNan; // Any NaN in gives quiet NaN out
		else if (aCls == clsInf && bCls == clsInf && effSub)
			invalidOp = 1'b1; // Inf minus inf
		else if (aCls == clsInf)
			specialWord = {a.sign, expMax, zeroFrac};
		else if (bCls == clsInf)
			specialWord = {bSign, expMax, zeroFrac};
		else if (aCls == clsZero && bCls == clsZero)
			specialWord = {a.sign & bSign, {`EXPONENT{1'b0}}, zeroFrac}; // -0 only for -0 + -0
		else
			special = 1'b0; // Regular datapath
	end

endmodule

// ==== hdl/fpAddExecute.sv ====
`timescale 1ns/1ns
`include "fpAddSettings.svh"

module fpAddExecute (
	input fpAddPkg::preSum bigSig,
	input fpAddPkg::preSum smallSig,
	input logic effSub,
	input logic bigSign,
	output fpAddPkg::preSum rawSum,
	output logic sumSign,
	output logic [`SHIFT_WIDTH-1:0] shift
);

	// Operands already ordered so the difference stays positive
	assign rawSum = effSub ? (bigSig - smallSig) : (bigSig + smallSig);
	assign sumSign = bigSign; // Larger operand sets the sign

	// Leading zeros below the carry bit
	// Highest set bit wins since the loop runs upward
	always_comb begin
		shift = `SHIFT_WIDTH'(`DWIDTH); // All-zero sum
		for (int i = 0; i < `DWIDTH; i++) begin
			if (rawSum[i])
				shift = `SHIFT_WIDTH'(`DWIDTH - 1 - i);
		end
		if (rawSum[`DWIDTH])
			shift = '0; // Carry out, shift handled in normalize
	end

endmodule

// ==== hdl/fpAddNormalizeShift1.sv ====
`timescale 1ns/1ns
`include "fpAddSettings.svh"

module fpAddNormalizeShift1 (
	input fpAddPkg::preSum rawSum,
	input logic [`SHIFT_WIDTH-1:0] shift,
	output fpAddPkg::preSum pssum
);

	logic carry; // Sum overflowed into bit 16
	logic [`DWIDTH-1:0] body; // Hidden one and everything below
	logic [`DWIDTH-1:0] bodyShifted;

	assign carry = rawSum[`DWIDTH];
	assign body = rawSum[`DWIDTH-1:0];

	// Leading one moves up to bit 15, zeros fill from below
	// Shift is zero whenever carry is set
	assign bodyShifted = body << shift;

	assign pssum = {carry, bodyShifted}; // Carry stays in place

endmodule

// ==== hdl/fpAddNormalizeShift2.sv ====
`timescale 1ns/1ns
`include "fpAddSettings.svh"

module fpAddNormalizeShift2 (
	input fpAddPkg::preSum pssum,
	input logic [`EXPONENT-1:0] cExp,
	input logic [`SHIFT_WIDTH-1:0] shift,
	output logic [`MANTISSA-1:0] normM,
	output logic [`EXPONENT:0] normE,
	output logic zeroSum,
	output logic negE,
	output logic fg,
	output logic r,
	output logic s
);

	logic msbShift; // Carry set, fields sit one place higher
	logic [`EXPONENT:0] expOk;

	assign msbShift = pssum[`DWIDTH];
	assign zeroSum = ~|pssum;

	// Exponent in 6-bit two's complement
	assign expOk = {1'b0, cExp} - {{(`EXPONENT+1-`SHIFT_WIDTH){1'b0}}, shift};
	assign normE = msbShift ? expOk + 1'b1 : expOk;
	assign negE = normE[`EXPONENT];

	// Fraction 15:6 on carry, else 14:5 under the hidden one
	assign normM = msbShift ? pssum[`DWIDTH-1:`EXPONENT+1] : pssum[`DWIDTH-2:`EXPONENT];
	assign fg = msbShift ? pssum[`EXPONENT] : pssum[`EXPONENT-1];
	assign r = msbShift ? pssum[`EXPONENT-1] : pssum[`EXPONENT-2];
	assign s = msbShift ? |pssum[`EXPONENT-2:0] : |pssum[`EXPONENT-3:0];

endmodule

// ==== hdl/fpAddRound.sv ====
`timescale 1ns/1ns
`include "fpAddSettings.svh"

module fpAddRound (
	input logic [`MANTISSA-1:0] normM,
	input logic [`EXPONENT:0] normE,
	input logic zeroSum,
	input logic negE,
	input logic fg,
	input logic r,
	input logic s,
	input logic sumSign,
	input logic special,
	input fpAddPkg::fpHalf specialWord,
	input logic invalidOp,
	output fpAddPkg::fpHalf word,
	output logic overflow,
	output logic underflow,
	output logic invalid,
	output logic inexact
);

	localparam logic [`EXPONENT-1:0] expMax = '1;

	logic roundUp;
	logic [`MANTISSA:0] mRound; // Top bit is the mantissa carry
	logic [`EXPONENT+1:0] eRound; // Wide enough for 31 plus a carry
	logic ovf;
	logic unf;

	// Nearest even, ties go to an even LSB
	assign roundUp = fg & (r | s | normM[0]);
	assign mRound = {1'b0, normM} + roundUp;
	assign eRound = {1'b0, normE} + mRound[`MANTISSA]; // Fraction wraps to zero on carry

	assign ovf = ~negE & (eRound >= {2'b00, expMax});
	assign unf = negE | (eRound == '0); // Below smallest normal

	always_comb begin
		word = {sumSign, eRound[`EXPONENT-1:0], mRound[`MANTISSA-1:0]};
		overflow = 1'b0;
		underflow = 1'b0;
		invalid = 1'b0;
		inexact = fg | r | s;
		if (special) begin
			word = specialWord; // NaN, inf or zero operands
			invalid = invalidOp;
			inexact = 1'b0;
		end else if (zeroSum) begin
			word = '0; // Exact cancellation is +0
		end else if (ovf) begin
			word = {sumSign, expMax, {`MANTISSA{1'b0}}};
			overflow = 1'b1;
			inexact = 1'b1;
		end else if (unf) begin
			word = {sumSign, {(`EXPONENT+`MANTISSA){1'b0}}}; // Flush to signed zero
			underflow = 1'b1;
		end
	end

endmodule

// ==== hdl/fpAddSub.sv ====
`timescale 1ns/1ns
`include "fpAddSettings.svh"

module fpAddSub (
	input logic clk,
	input logic reset,
	input logic inValid,
	input fpAddPkg::fpHalf a,
	input fpAddPkg::fpHalf b,
	input logic op,
	output logic outValid,
	output fpAddPkg::fpHalf result,
	output logic overflow,
	output logic underflow,
	output logic invalid,
	output logic inexact
);
	import fpAddPkg::*;

	// Align stage outputs and stage 1 registers
	logic alBigSign, alEffSub, alSpecial, alInvalidOp;
	logic [`EXPONENT-1:0] alBigExp;
	preSum alBigSig, alSmallSig;
	fpHalf alSpecialWord;
	logic v1, s1BigSign, s1EffSub, s1Special, s1InvalidOp;
	logic [`EXPONENT-1:0] s1BigExp;
	preSum s1BigSig, s1SmallSig;
	fpHalf s1SpecialWord;

	// Execute outputs and stage 2 registers
	preSum exRawSum;
	logic exSumSign;
	logic [`SHIFT_WIDTH-1:0] exShift;
	logic v2, s2SumSign, s2Special, s2InvalidOp;
	preSum s2RawSum;
	logic [`SHIFT_WIDTH-1:0] s2Shift;
	logic [`EXPONENT-1:0] s2Exp;
	fpHalf s2SpecialWord;

	// Normalize outputs and stage 3 registers
	preSum nmPssum;
	logic [`MANTISSA-1:0] nmNormM;
	logic [`EXPONENT:0] nmNormE;
	logic nmZeroSum, nmNegE, nmFg, nmR, nmS;
	logic v3, s3SumSign, s3Special, s3InvalidOp;
	logic [`MANTISSA-1:0] s3NormM;
	logic [`EXPONENT:0] s3NormE;
	logic s3ZeroSum, s3NegE, s3Fg, s3R, s3S;
	fpHalf s3SpecialWord;

	// Round outputs feed the output register
	fpHalf rdWord;
	logic rdOverflow, rdUnderflow, rdInvalid, rdInexact;

	fpAddAlign align (
		.a(a), .b(b), .op(op),
		.bigSign(alBigSign), .bigExp(alBigExp),
		.bigSig(alBigSig), .smallSig(alSmallSig), .effSub(alEffSub),
		.special(alSpecial), .specialWord(alSpecialWord), .invalidOp(alInvalidOp)
	);

	fpAddExecute execute (
		.bigSig(s1BigSig), .smallSig(s1SmallSig), .effSub(s1EffSub), .bigSign(s1BigSign),
		.rawSum(exRawSum), .sumSign(exSumSign), .shift(exShift)
	);

	fpAddNormalizeShift1 normShift1 (
		.rawSum(s2RawSum), .shift(s2Shift), .pssum(nmPssum)
	);

	fpAddNormalizeShift2 normShift2 (
		.pssum(nmPssum), .cExp(s2Exp), .shift(s2Shift),
		.normM(nmNormM), .normE(nmNormE), .zeroSum(nmZeroSum), .negE(nmNegE),
		.fg(nmFg), .r(nmR), .s(nmS)
	);

	fpAddRound round (
		.normM(s3NormM), .normE(s3NormE), .zeroSum(s3ZeroSum), .negE(s3NegE),
		.fg(s3Fg), .r(s3R), .s(s3S), .sumSign(s3SumSign),
		.special(s3Special), .specialWord(s3SpecialWord), .invalidOp(s3InvalidOp),
		.word(rdWord), .overflow(rdOverflow), .underflow(rdUnderflow),
		.invalid(rdInvalid), .inexact(rdInexact)
	);

	// Valid chain, four cycles input to output
	always_ff @(posedge clk) begin
		if (reset) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			v3 <= 1'b0;
			outValid <= 1'b0;
		end else begin
			v1 <= inValid;
			v2 <= v1;
			v3 <= v2;
			outValid <= v3;
		end
	end

	// Payload registers, loaded every cycle
	always_ff @(posedge clk) begin
		s1BigSign <= alBigSign;
		s1BigExp <= alBigExp;
		s1BigSig <= alBigSig;
		s1SmallSig <= alSmallSig;
		s1EffSub <= alEffSub;
		s1Special <= alSpecial;
		s1SpecialWord <= alSpecialWord;
		s1InvalidOp <= alInvalidOp;

		s2RawSum <= exRawSum;
		s2SumSign <= exSumSign;
		s2Shift <= exShift;
		s2Exp <= s1BigExp; // Common exponent rides along
		s2Special <= s1Special;
		s2SpecialWord <= s1SpecialWord;
		s2InvalidOp <= s1InvalidOp;

		s3NormM <= nmNormM;
		s3NormE <= nmNormE;
		s3ZeroSum <= nmZeroSum;
		s3NegE <= nmNegE;
		s3Fg <= nmFg;
		s3R <= nmR;
		s3S <= nmS;
		s3SumSign <= s2SumSign;
		s3Special <= s2Special;
		s3SpecialWord <= s2SpecialWord;
		s3InvalidOp <= s2InvalidOp;

		result <= rdWord;
		overflow <= rdOverflow;
		underflow <= rdUnderflow;
		invalid <= rdInvalid;
		inexact <= rdInexact;
	end

endmodule

// ==== tb/fpAddRefModel.svh ====
`ifndef FP_ADD_REF_MODEL_SVH
`define FP_ADD_REF_MODEL_SVH

// Galois LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsrNext(input logic [15:0] s);
	return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

// Exact integer sum, then flush, RNE and IEEE special rules
// Returns {word, overflow, underflow, invalid, inexact}
function automatic logic [19:0] refAdd(input logic [15:0] x, input logic [15:0] y,
		input logic sub);
	logic sx, sy, sr, inx;
	int ex, ey, e, p, drop;
	longint mx, my, sum, keep, rem, half;
	sx = x[15];
	sy = y[15] ^ sub; // Subtract flips sign of y
	ex = x[14:10];
	ey = y[14:10];
	if ((ex == 31 && x[9:0] != 0) || (ey == 31 && y[9:0] != 0))
		return {16'h7E00, 4'b0000}; // Quiet NaN
	if (ex == 31 && ey == 31 && sx != sy)
		return {16'h7E00, 4'b0010}; // Inf minus inf
	if (ex == 31)
		return {sx, 15'h7C00, 4'b0000};
	if (ey == 31)
		return {sy, 15'h7C00, 4'b0000};
	if (ex == 0 && ey == 0)
		return {sx & sy, 15'h0000, 4'b0000}; // Both zero or subnormal
	mx = (ex == 0) ? 0 : 1024 + x[9:0]; // Subnormals count as zero
	my = (ey == 0) ? 0 : 1024 + y[9:0];
	e = (ex < ey) ? ex : ey; // Common exponent
	mx = mx << (ex - e);
	my = my << (ey - e);
	sum = (sx ? -mx : mx) + (sy ? -my : my);
	if (sum == 0)
		return {16'h0000, 4'b0000}; // Exact cancellation
	sr = sum < 0;
	if (sr)
		sum = -sum;
	p = 0;
	while ((sum >> (p + 1)) != 0)
		p++; // Leading one position
	e = e + p - 10; // Biased exponent of the leading one
	inx = 1'b0;
	if (p > 10) begin
		drop = p - 10;
		keep = sum >> drop;
		rem = sum - (keep << drop);
		half = longint'(1) << (drop - 1);
		inx = rem != 0;
		if (rem > half || (rem == half && keep[0]))
			keep++; // Nearest, ties to even
		if (keep == 2048) begin
			keep = 1024; // Mantissa carry
			e++;
		end
	end else
		keep = sum << (10 - p);
	if (e >= 31)
		return {sr, 15'h7C00, 4'b1001};
	if (e <= 0)
		return {sr, 15'h0000, 3'b010, inx}; // Flush to signed zero
	return {sr, 5'(e), 10'(keep), 3'b000, inx};
endfunction

`endif

// ==== tb/fpAddSubTb.sv ====
`timescale 1ns/1ns

module fpAddSubTb;

	logic clk, reset, inValid, op;
	logic [15:0] a, b;
	logic outValid, overflow, underflow, invalid, inexact;
	logic [15:0] result;

	logic [19:0] expQ[$]; // Expected word and flags
	int cycQ[$]; // Issue cycle of each operation
	int cycleCount = 0;
	int checks = 0;
	int errors = 0;
	logic [15:0] lfsr = 16'd89;

	// Ops of all tests plus 4 cycles latency per test and a margin
	localparam int opCount = 3 + 4 + 4 + 6 + 200 + 11;
	localparam int cycleLimit = opCount + 4 * 6 + 100;

	`include "fpAddRefModel.svh"

	fpAddSub UUT (
		.clk(clk), .reset(reset), .inValid(inValid), .a(a), .b(b), .op(op),
		.outValid(outValid), .result(result), .overflow(overflow),
		.underflow(underflow), .invalid(invalid), .inexact(inexact)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: run exceeded %0d cycles", cycleLimit);
			$display("Test FAILED");
			$finish;
		end
	end

	// Outputs change on posedge and are stable at the falling edge
	always @(negedge clk) begin : monitor
		logic [19:0] want;
		int issued;
		if (outValid === 1'b1) begin
			if (expQ.size() == 0) begin
				$display("Unexpected outValid at %0t ns with no operation pending", $time);
				errors++;
			end else begin
				want = expQ.pop_front();
				issued = cycQ.pop_front();
				checks++;
				if ({result, overflow, underflow, invalid, inexact} !== want) begin
					$display("ERROR at %0t ns: got %h flags %b, expected %h flags %b", $time,
						result, {overflow, underflow, invalid, inexact}, want[19:4], want[3:0]);
					errors++;
				end
				if (cycleCount - issued != 4) begin
					$display("ERROR at %0t ns: latency %0d cycles, expected 4", $time,
						cycleCount - issued);
					errors++;
				end
			end
		end
	end

	function automatic logic [15:0] takeBits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr[0]}; // One LFSR step per bit
			lfsr = lfsrNext(lfsr);
		end
		return v;
	endfunction

	task automatic issue(input logic [15:0] x, input logic [15:0] y, input logic o);
		@(negedge clk);
		a = x;
		b = y;
		op = o;
		inValid = 1'b1;
		expQ.push_back(refAdd(x, y, o));
		cycQ.push_back(cycleCount);
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		@(negedge clk);
		inValid = 1'b0;
		while (expQ.size() != 0 && waited < 10) begin
			@(posedge clk);
			waited++;
		end
		if (expQ.size() != 0) begin
			$display("Missing outValid: %0d results never came out", expQ.size());
			errors++;
			expQ.delete();
			cycQ.delete();
		end
	endtask

	task automatic report(input string name, input int c0, input int e0);
		$display("%-16s %0d results checked, %0d errors", name, checks - c0, errors - e0);
	endtask

	task automatic exactSums();
		int c0, e0;
		c0 = checks;
		e0 = errors;
		issue(16'h3C00, 16'h4000, 1'b0); // 1 + 2
		issue(16'h4200, 16'h4500, 1'b1); // 3 - 5
		issue(16'h3800, 16'h3400, 1'b0); // 0.5 + 0.25
		drain();
		report("exactSums", c0, e0);
	endtask

	task automatic cancellation();
		int c0, e0;
		c0 = checks;
		e0 = errors;
		issue(16'hC248, 16'hC248, 1'b1); // x - x with x negative
		issue(16'h8000, 16'h8000, 1'b0); // -0 + -0
		issue(16'h3C01, 16'h3C00, 1'b1); // Shift by 10
		issue(16'h4000, 16'h3FFF, 1'b1);
		drain();
		report("cancellation", c0, e0);
	endtask

	task automatic rounding();
		int c0, e0;
		c0 = checks;
		e0 = errors;
		issue(16'h3C00, 16'h1000, 1'b0); // Tie stays even
		issue(16'h3C01, 16'h1000, 1'b0); // Tie rounds up to even
		issue(16'h3C00, 16'h1001, 1'b0); // Above half
		issue(16'h3FFF, 16'h1000, 1'b0); // Mantissa carry
		drain();
		report("rounding", c0, e0);
	endtask

	task automatic exceptions();
		int c0, e0;
		c0 = checks;
		e0 = errors;
		issue(16'h7BFF, 16'h7BFF, 1'b0); // Overflow
		issue(16'h0401, 16'h0400, 1'b1); // Underflow
		issue(16'h7C00, 16'h7C00, 1'b1);
		issue(16'h7D00, 16'h3C00, 1'b0); // NaN in
		issue(16'h7C00, 16'h3C00, 1'b0);
		issue(16'hBC00, 16'hFC00, 1'b1); // -1 minus -inf
		drain();
		report("exceptions", c0, e0);
	endtask

	task automatic randomStream();
		int c0, e0;
		logic [15:0] x, y;
		c0 = checks;
		e0 = errors;
		for (int i = 0; i < 200; i++) begin
			x = takeBits(16);
			y = takeBits(16);
			if (takeBits(1) != 0)
				y[14:10] = x[14:10] ^ {3'b000, y[11:10]}; // Keep exponents close
			issue(x, y, takeBits(1) != 0);
		end
		drain();
		report("randomStream", c0, e0);
	endtask

	task automatic midStreamReset();
		int c0, e0;
		logic [15:0] x, y;
		c0 = checks;
		e0 = errors;
		for (int i = 0; i < 11; i++) begin
			x = takeBits(16);
			y = takeBits(16);
			issue(x, y, 1'b0);
			if (i == 7) begin
				@(negedge clk);
				inValid = 1'b0;
				reset = 1'b1; // Three operations still in flight
				@(negedge clk);
				if (outValid !== 1'b0) begin
					$display("ERROR at %0t ns: outValid still high after reset", $time);
					errors++;
				end
				expQ.delete(); // Those results are dropped
				cycQ.delete();
				@(negedge clk);
				reset = 1'b0;
				repeat (10) @(negedge clk); // Any outValid here is stale
			end
		end
		drain();
		report("midStreamReset", c0, e0);
	endtask

	initial begin
		reset = 1'b1;
		inValid = 1'b0;
		a = '0;
		b = '0;
		op = 1'b0;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		exactSums();
		cancellation();
		rounding();
		exceptions();
		randomStream();
		midStreamReset();
		$display("%0d results checked, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+hdl
+incdir+tb
hdl/fpAddPkg.sv
hdl/fpAddAlign.sv
hdl/fpAddExecute.sv
hdl/fpAddNormalizeShift1.sv
hdl/fpAddNormalizeShift2.sv
hdl/fpAddRound.sv
hdl/fpAddSub.sv
tb/fpAddSubTb.sv
